// ==== filelist.f ====
source/kicker_pkg.sv
source/kicker_frac_cen.sv
source/kicker_dwnld.sv
source/kicker_rom_slots.sv
source/kicker_game.sv
verification/tb_clock.sv
verification/kicker_game_sva.sv
verification/tb_kicker_game.sv

// ==== run.sh ====
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
    --top-module tb_kicker_game -f filelist.f -o tb_kicker_game

output=$(./obj_dir/tb_kicker_game 2>&1 || true)
echo "$output"

if grep -qx "Simulation passed" <<< "$output"; then
    exit 0
fi
exit 1

// ==== verification/tb_kicker_game.sv ====
`timescale 1ns/1ps

module tb_kicker_game;

    import kicker_pkg::*;

    localparam ioctl_addr_t PROM_START  = 25'h140000;
    localparam sdram_addr_t GFX_OFFSET  = 22'h10000;
    localparam sdram_addr_t MAIN_OFFSET = 22'h0;
    localparam int          PERIOD      = 20;
    localparam int          CEN_CYCLES  = 1000;
    localparam int          N_PROG      = 12;
    localparam int          N_PROM      = 12;
    localparam int          OK_TIMEOUT  = 40;   // Cycles allowed for one ROM read
    // Reset, then the six tests in order
    localparam int          BUDGET      = 10 + CEN_CYCLES + N_PROG * 22 + N_PROM * 2
                                          + 3 * (OK_TIMEOUT + 8) + 52 + OK_TIMEOUT;

    logic        clk;
    logic        arst_n;
    logic        pxl_cen;
    logic        pxl2_cen;
    logic        downloading;
    logic        dwnld_busy;
    ioctl_addr_t ioctl_addr;
    byte_t       ioctl_dout;
    logic        ioctl_wr;
    prog_wr_t    prog;
    logic        prog_we;
    prom_wr_t    prom;
    logic        prom_we;
    slot_req_t   gfx_req;
    logic        gfx_ok;
    word_t       gfx_data;
    slot_req_t   main_req;
    logic        main_ok;
    byte_t       main_data;
    rom_port_t   sdram;
    logic        sdram_ack;
    logic        data_rdy;
    word_t       data_read;

    int          seed = 44750;
    int          errors = 0;
    int          failed_tests = 0;
    int          req_count = 0;     // SDRAM reads seen by the model
    int          prog_acks = 0;
    sdram_addr_t req_log[$];
    prog_wr_t    prog_log[$];

    tb_clock #(.PERIOD(PERIOD), .RESET_CYCLES(3)) clock0 (.clk(clk), .arst_n(arst_n));

    kicker_game dut0 (.*);

    // SDRAM controller model, samples at +1 ns and drives at +2 ns
    initial begin : sdram_model
        sdram_addr_t rd_addr;
        sdram_ack = 1'b0;
        data_rdy  = 1'b0;
        data_read = '0;
        forever begin
            @(posedge clk);
            #1;
            if (prog_we) begin
                prog_log.push_back(prog);
                repeat (2) @(posedge clk);
                #2 sdram_ack = 1'b1;
                @(posedge clk);
                prog_acks++;                // Ack taken by the DUT at this edge
                #2 sdram_ack = 1'b0;
            end else if (sdram.req) begin
                rd_addr = sdram.addr;
                req_count++;
                req_log.push_back(rd_addr);
                repeat (2) @(posedge clk);
                #2 sdram_ack = 1'b1;
                @(posedge clk);
                #2 sdram_ack = 1'b0;
                repeat (2) @(posedge clk);
                #2 data_rdy = 1'b1;
                data_read = word_t'(rd_addr) ^ 16'hA5C3;
                @(posedge clk);
                #2 data_rdy = 1'b0;
            end
        end
    end

    initial begin : watchdog
        #(BUDGET * 4 * PERIOD);
        $display("Run stopped by the watchdog after %0d cycles", BUDGET * 4);
        $display("Simulation failed");
        $finish;
    end

    task automatic tick();
        @(posedge clk);
        #2;
    endtask

    task automatic report_mismatch(input string name, input logic [31:0] got,
                                   input logic [31:0] exp);
        $display("FAIL %s: got 0x%h expected 0x%h", name, got, exp);
        errors++;
    endtask

    task automatic check_word(input string name, input word_t got, input word_t exp);
        if (got !== exp) report_mismatch(name, 32'(got), 32'(exp));
    endtask

    task automatic check_byte(input string name, input byte_t got, input byte_t exp);
        if (got !== exp) report_mismatch(name, 32'(got), 32'(exp));
    endtask

    task automatic check_prog(input string name, input prog_wr_t got, input prog_wr_t exp);
        if (got !== exp) report_mismatch(name, 32'(got), 32'(exp));
    endtask

    task automatic check_prom(input string name, input prom_wr_t got, input prom_wr_t exp);
        if (got !== exp) report_mismatch(name, 32'(got), 32'(exp));
    endtask

    task automatic check_addr(input string name, input sdram_addr_t got,
                              input sdram_addr_t exp);
        if (got !== exp) report_mismatch(name, 32'(got), 32'(exp));
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) report_mismatch(name, 32'(got), 32'(exp));
    endtask

    task automatic check_count(input string name, input int got, input int exp);
        if (got != exp) report_mismatch(name, got, exp);
    endtask

    task automatic wait_for_ok(input logic use_main);
        int n = 0;
        while (!(use_main ? main_ok : gfx_ok) && n < OK_TIMEOUT) begin
            tick();
            n++;
        end
        if (!(use_main ? main_ok : gfx_ok)) begin
            $display("%s did not rise within %0d cycles", use_main ? "main_ok" : "gfx_ok",
                     OK_TIMEOUT);
            errors++;
        end
    endtask

    task automatic report_test(input string name, input int errors_before);
        if (errors == errors_before) begin
            $display("test %s: ok", name);
        end else begin
            $display("test %s: %0d errors", name, errors - errors_before);
            failed_tests++;
        end
    endtask

    task automatic cen_rates();
        int n_pxl = 0;
        int n_pxl2 = 0;
        int since = 0;                      // pxl_cen pulses since last pxl2_cen
        for (int i = 0; i < CEN_CYCLES; i++) begin
            tick();
            n_pxl  += int'(pxl_cen);
            since  += int'(pxl_cen);
            if (pxl2_cen) begin
                n_pxl2++;
                check_bit("pxl_cen with pxl2_cen", pxl_cen, 1'b1);
                check_count("pxl_cen pulses per pxl2_cen", since, 2);
                since = 0;
            end
        end
        check_count("pxl_cen pulses", n_pxl, 128);
        check_count("pxl2_cen pulses", n_pxl2, 64);
    endtask

    task automatic sdram_region_download();
        ioctl_addr_t a;
        byte_t       d;
        prog_wr_t    exp;
        int          acks;
        int          n;
        downloading = 1'b1;
        tick();
        check_bit("dwnld_busy", dwnld_busy, 1'b1);
        for (int i = 0; i < N_PROG; i++) begin
            a        = ioctl_addr_t'({$random(seed)} % PROM_START);
            a[0]     = i[0];                // Even and odd in turn
            d        = byte_t'($random(seed));
            exp.addr = sdram_addr_t'(a >> 1);
            exp.data = d;
            exp.mask = a[0] ? 2'b10 : 2'b01;
            acks     = prog_acks;
            ioctl_addr = a;
            ioctl_dout = d;
            ioctl_wr   = 1'b1;
            tick();
            ioctl_wr   = 1'b0;
            check_bit("prog_we", prog_we, 1'b1);
            n = 0;
            while (prog_we && n < 20) begin
                check_prog("prog", prog, exp);
                tick();
                n++;
            end
            if (prog_we) begin
                $display("prog_we never dropped for the write to 0x%h", a);
                errors++;
            end
            check_count("SDRAM acks before prog_we fell", prog_acks - acks, 1);
            if (prog_log.size() == 0) begin
                $display("SDRAM model saw no programming write for 0x%h", a);
                errors++;
            end else begin
                check_prog("logged prog", prog_log.pop_front(), exp);
            end
        end
    endtask

    task automatic prom_region_download();
        prom_addr_t off;
        byte_t      d;
        prom_wr_t   exp;
        for (int i = 0; i < N_PROM; i++) begin
            off        = prom_addr_t'({$random(seed)} % 512);
            d          = byte_t'($random(seed));
            exp.addr   = off;
            exp.data   = d[3:0];
            ioctl_addr = PROM_START + ioctl_addr_t'(off);
            ioctl_dout = d;
            ioctl_wr   = 1'b1;
            tick();
            ioctl_wr   = 1'b0;
            check_bit("prom_we", prom_we, 1'b1);
            check_prom("prom", prom, exp);
            check_bit("prog_we on PROM byte", prog_we, 1'b0);
            tick();
            check_bit("prom_we second cycle", prom_we, 1'b0);
            check_bit("prog_we on PROM byte", prog_we, 1'b0);
        end
        downloading = 1'b0;
        tick();
        check_bit("dwnld_busy after download", dwnld_busy, 1'b0);
    endtask

    task automatic gfx_slot_read();
        gfx_addr_t   ga;
        sdram_addr_t sa;
        int          reqs;
        ga   = gfx_addr_t'($random(seed));
        sa   = GFX_OFFSET + sdram_addr_t'(ga);
        reqs = req_count;
        gfx_req.addr = ga;
        gfx_req.cs   = 1'b1;
        tick();
        wait_for_ok(1'b0);
        check_word("gfx_data", gfx_data, word_t'(sa) ^ 16'hA5C3);
        check_count("SDRAM reads for a gfx miss", req_count - reqs, 1);
        if (req_log.size() > 0) check_addr("sdram.addr", req_log[$], sa);
        gfx_req.cs = 1'b0;
        tick();
        check_bit("gfx_ok without cs", gfx_ok, 1'b0);
        gfx_req.cs = 1'b1;                  // Same address again hits the cache
        repeat (5) begin
            tick();
            check_bit("gfx_ok on repeat", gfx_ok, 1'b1);
        end
        check_count("SDRAM reads for a gfx hit", req_count - reqs, 1);
        gfx_req.cs = 1'b0;
        tick();
    endtask

    task automatic both_slots_miss();
        gfx_addr_t   ga;
        main_addr_t  ma;
        sdram_addr_t sm;
        word_t       w;
        int          first;
        for (int k = 0; k < 2; k++) begin
            ga    = gfx_addr_t'($random(seed));
            ma    = main_addr_t'($random(seed));
            ma[0] = k[0];
            sm    = MAIN_OFFSET + sdram_addr_t'(ma >> 1);
            w     = word_t'(sm) ^ 16'hA5C3;
            first = req_log.size();
            gfx_req.addr  = ga;
            gfx_req.cs    = 1'b1;
            main_req.addr = gfx_addr_t'(ma);
            main_req.cs   = 1'b1;
            tick();
            wait_for_ok(1'b1);
            if (req_log.size() < first + 2) begin
                $display("Expected a graphics read and a main read, saw %0d reads",
                         req_log.size() - first);
                errors++;
            end else begin
                check_addr("first sdram.addr", req_log[first], GFX_OFFSET + sdram_addr_t'(ga));
                check_addr("second sdram.addr", req_log[first + 1], sm);
            end
            check_byte("main_data", main_data, ma[0] ? w[7:0] : w[15:8]);
            check_bit("gfx_ok", gfx_ok, 1'b1);
            gfx_req.cs  = 1'b0;
            main_req.cs = 1'b0;
            tick();
        end
    endtask

    task automatic download_blocks_reads();
        gfx_addr_t   ga;
        sdram_addr_t sa;
        int          reqs;
        int          busy = 0;              // Cycles with sdram.req high
        ga   = gfx_addr_t'($random(seed));
        sa   = GFX_OFFSET + sdram_addr_t'(ga);
        reqs = req_count;
        downloading  = 1'b1;
        gfx_req.addr = ga;
        gfx_req.cs   = 1'b1;
        repeat (50) begin
            tick();
            busy += int'(sdram.req);
        end
        check_count("cycles with sdram.req during download", busy, 0);
        check_count("SDRAM reads during download", req_count - reqs, 0);
        check_bit("dwnld_busy", dwnld_busy, 1'b1);
        downloading = 1'b0;
        tick();
        wait_for_ok(1'b0);
        check_word("gfx_data after download", gfx_data, word_t'(sa) ^ 16'hA5C3);
        gfx_req.cs = 1'b0;
        tick();
    endtask

    initial begin : main_seq
        int e0;
        downloading = 1'b0;
        ioctl_addr  = '0;
        ioctl_dout  = '0;
        ioctl_wr    = 1'b0;
        gfx_req     = '0;
        main_req    = '0;
        wait (arst_n === 1'b1);
        e0 = errors;
        cen_rates();
        report_test("clock enables", e0);
        e0 = errors;
        sdram_region_download();
        report_test("SDRAM region download", e0);
        e0 = errors;
        prom_region_download();
        report_test("PROM region download", e0);
        e0 = errors;
        gfx_slot_read();
        report_test("graphics slot read", e0);
        e0 = errors;
        both_slots_miss();
        report_test("main slot read with both missing", e0);
        e0 = errors;
        download_blocks_reads();
        report_test("downloading blocks reads", e0);
        $display("tests run 6, tests failed %0d, checks failed %0d", failed_tests, errors);
        if (errors == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// ==== verification/kicker_game_sva.sv ====
`timescale 1ns/1ps

module kicker_game_sva #(
    parameter int W            = 22,
    parameter bit CHECK_STROBE = 1'b1
) (
    input logic         clk,
    input logic         arst_n,
    input logic         valid,          // sdram.req or prog_we
    input logic [W-1:0] fields,
    input logic         ack,
    input logic         strobe          // Single cycle write strobe
);

    // Request holds until the controller acknowledges it
    hold_until_ack: assert property (
        @(posedge clk) disable iff (!arst_n) valid && !ack |=> valid
    ) else $error("request dropped before sdram_ack");

    fields_stable: assert property (
        @(posedge clk) disable iff (!arst_n) valid && !ack |=> $stable(fields)
    ) else $error("request fields changed while waiting for sdram_ack");

    drop_after_ack: assert property (
        @(posedge clk) disable iff (!arst_n) valid && ack |=> !valid
    ) else $error("request still high the cycle after sdram_ack");

    // Only the download side has a write strobe
    if (CHECK_STROBE) begin : g_strobe
        strobe_one_cycle: assert property (
            @(posedge clk) disable iff (!arst_n) strobe |=> !strobe
        ) else $error("prom_we high for more than one cycle");
    end

endmodule

bind kicker_rom_slots kicker_game_sva #(.W(22), .CHECK_STROBE(1'b0)) sva_rom (
    .clk(clk), .arst_n(arst_n), .valid(sdram.req), .fields(sdram.addr),
    .ack(sdram_ack), .strobe(1'b0)
);

bind kicker_dwnld kicker_game_sva #(.W(32)) sva_dwnld (
    .clk(clk), .arst_n(arst_n), .valid(prog_we), .fields(prog),
    .ack(sdram_ack), .strobe(prom_we)
);

// ==== verification/tb_clock.sv ====
`timescale 1ns/1ps

module tb_clock #(
    parameter int PERIOD       = 20,
    parameter int RESET_CYCLES = 3
) (
    output logic clk,
    output logic arst_n
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    initial begin
        arst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        #2 arst_n = 1'b1;                   // Released just after an edge
    end

endmodule

// ==== source/kicker_game.sv ====
`timescale 1ns/1ps

module kicker_game #(
    parameter kicker_pkg::ioctl_addr_t PROM_START  = 25'h140000,
    parameter kicker_pkg::sdram_addr_t GFX_OFFSET  = 22'h10000,
    parameter kicker_pkg::sdram_addr_t MAIN_OFFSET = 22'h0,
    parameter int                      CEN_N       = 16,
    parameter int                      CEN_M       = 125
) (
    input  logic                    clk,
    input  logic                    arst_n,
    output logic                    pxl_cen,
    output logic                    pxl2_cen,
    // ROM download
    input  logic                    downloading,
    output logic                    dwnld_busy,
    input  kicker_pkg::ioctl_addr_t ioctl_addr,
    input  kicker_pkg::byte_t       ioctl_dout,
    input  logic                    ioctl_wr,
    output kicker_pkg::prog_wr_t    prog,
    output logic                    prog_we,
    output kicker_pkg::prom_wr_t    prom,
    output logic                    prom_we,
    // ROM clients
    input  kicker_pkg::slot_req_t   gfx_req,
    output logic                    gfx_ok,
    output kicker_pkg::word_t       gfx_data,
    input  kicker_pkg::slot_req_t   main_req,
    output logic                    main_ok,
    output kicker_pkg::byte_t       main_data,
    // SDRAM
    output kicker_pkg::rom_port_t   sdram,
    input  logic                    sdram_ack,
    input  logic                    data_rdy,
    input  kicker_pkg::word_t       data_read
);

    logic [1:0] cen_base;

    assign dwnld_busy = downloading;
    assign pxl_cen    = cen_base[0];
    assign pxl2_cen   = cen_base[1];    // Half of pxl_cen

    kicker_frac_cen #(
        .W          ( 2             ),
        .N          ( CEN_N         ),
        .M          ( CEN_M         )
    ) u_cen (
        .clk        ( clk           ),
        .arst_n     ( arst_n        ),
        .cen        ( cen_base      )
    );

    kicker_dwnld #(
        .PROM_START ( PROM_START    )
    ) u_dwnld (
        .clk        ( clk           ),
        .arst_n     ( arst_n        ),
        .downloading( downloading   ),
        .ioctl_addr ( ioctl_addr    ),
        .ioctl_dout ( ioctl_dout    ),
        .ioctl_wr   ( ioctl_wr      ),
        .sdram_ack  ( sdram_ack     ),  // Shared with the fetcher
        .prog       ( prog          ),
        .prog_we    ( prog_we       ),
        .prom       ( prom          ),
        .prom_we    ( prom_we       )
    );

    kicker_rom_slots #(
        .GFX_OFFSET ( GFX_OFFSET    ),
        .MAIN_OFFSET( MAIN_OFFSET   )
    ) u_rom (
        .clk        ( clk           ),
        .arst_n     ( arst_n        ),
        .downloading( downloading   ),  // Reads held off while high
        .gfx_req    ( gfx_req       ),
        .gfx_ok     ( gfx_ok        ),
        .gfx_data   ( gfx_data      ),
        .main_req   ( main_req      ),
        .main_ok    ( main_ok       ),
        .main_data  ( main_data     ),
        .sdram      ( sdram         ),
        .sdram_ack  ( sdram_ack     ),
        .data_rdy   ( data_rdy      ),
        .data_read  ( data_read     )
    );

endmodule

// ==== source/kicker_rom_slots.sv ====
`timescale 1ns/1ps

module kicker_rom_slots #(
    parameter kicker_pkg::sdram_addr_t GFX_OFFSET  = 22'h10000,
    parameter kicker_pkg::sdram_addr_t MAIN_OFFSET = 22'h0
) (
    input  logic                    clk,
    input  logic                    arst_n,
    input  logic                    downloading,
    // ROM clients
    input  kicker_pkg::slot_req_t   gfx_req,
    output logic                    gfx_ok,
    output kicker_pkg::word_t       gfx_data,
    input  kicker_pkg::slot_req_t   main_req,
    output logic                    main_ok,
    output kicker_pkg::byte_t       main_data,
    // SDRAM read port
    output kicker_pkg::rom_port_t   sdram,
    input  logic                    sdram_ack,
    input  logic                    data_rdy,
    input  kicker_pkg::word_t       data_read
);

    import kicker_pkg::*;

    typedef enum logic [1:0] {
        idle,
        wait_ack,
        wait_data
    } state_t;

    state_t      state;
    logic        serve_main;            // Owner of the outstanding read
    logic        gfx_valid;
    logic        main_valid;
    gfx_addr_t   gfx_cache_addr;
    word_t       gfx_cache_data;
    logic [15:0] main_cache_word;       // Main cache tag is a word address
    word_t       main_cache_data;
    main_addr_t  main_addr;
    logic [15:0] main_word;
    logic        gfx_hit;
    logic        main_hit;
    logic        gfx_miss;
    logic        main_miss;
    logic        issue_gfx;
    logic        issue_main;
    logic        fill;

    assign main_addr  = main_addr_t'(main_req.addr);
    assign main_word  = main_addr[16:1];

    assign gfx_hit    = gfx_valid && gfx_cache_addr == gfx_req.addr;
    assign main_hit   = main_valid && main_cache_word == main_word;
    assign gfx_miss   = gfx_req.cs && !gfx_hit;
    assign main_miss  = main_req.cs && !main_hit;

    // Fixed priority, graphics first
    assign issue_gfx  = state == idle && !downloading && gfx_miss;
    assign issue_main = state == idle && !downloading && main_miss && !gfx_miss;
    assign fill       = state == wait_data && data_rdy;

    assign gfx_ok     = gfx_req.cs && gfx_hit;
    assign gfx_data   = gfx_cache_data;
    assign main_ok    = main_req.cs && main_hit;
    assign main_data  = main_addr[0] ? main_cache_data[7:0] : main_cache_data[15:8];

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state      <= idle;
            sdram      <= '0;
            serve_main <= 1'b0;
        end else begin
            case (state)
                idle: begin
                    if (issue_gfx) begin
                        sdram.req  <= 1'b1;
                        sdram.addr <= gfx_to_sdram(GFX_OFFSET, gfx_req.addr);
                        serve_main <= 1'b0;
                        state      <= wait_ack;
                    end else if (issue_main) begin
                        sdram.req  <= 1'b1;
                        sdram.addr <= main_to_sdram(MAIN_OFFSET, main_addr);
                        serve_main <= 1'b1;
                        state      <= wait_ack;
                    end
                end
                wait_ack: begin
                    if (sdram_ack) begin
                        sdram.req <= 1'b0;      // Address held up to here
                        state     <= wait_data;
                    end
                end
                wait_data: begin
                    if (data_rdy) state <= idle;
                end
                default: state <= idle;
            endcase
        end
    end

    // Valid flags, all dropped during download
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            gfx_valid  <= 1'b0;
            main_valid <= 1'b0;
        end else if (downloading) begin
            gfx_valid  <= 1'b0;
            main_valid <= 1'b0;
        end else begin
            if (issue_gfx) begin
                gfx_valid <= 1'b0;
            end else if (fill && !serve_main) begin
                gfx_valid <= 1'b1;
            end
            if (issue_main) begin
                main_valid <= 1'b0;
            end else if (fill && serve_main) begin
                main_valid <= 1'b1;
            end
        end
    end

    // Tags load on issue, data on fill
    always_ff @(posedge clk) begin
        if (issue_gfx)  gfx_cache_addr  <= gfx_req.addr;
        if (issue_main) main_cache_word <= main_word;
        if (fill && !serve_main) gfx_cache_data  <= data_read;
        if (fill && serve_main)  main_cache_data <= data_read;
    end

endmodule

// ==== source/kicker_dwnld.sv ====
`timescale 1ns/1ps

module kicker_dwnld #(
    parameter kicker_pkg::ioctl_addr_t PROM_START = 25'h140000
) (
    input  logic                    clk,
    input  logic                    arst_n,
    input  logic                    downloading,
    // Loader byte stream
    input  kicker_pkg::ioctl_addr_t ioctl_addr,
    input  kicker_pkg::byte_t       ioctl_dout,
    input  logic                    ioctl_wr,
    // SDRAM programming port
    input  logic                    sdram_ack,
    output kicker_pkg::prog_wr_t    prog,
    output logic                    prog_we,
    // PROM write port
    output kicker_pkg::prom_wr_t    prom,
    output logic                    prom_we
);

    import kicker_pkg::*;

    ioctl_addr_t prom_offset;
    logic        is_prom;
    logic        accept;
    logic        take_prog;
    logic        take_prom;

    // Bytes are lost while an SDRAM write is still pending
    assign accept      = downloading && ioctl_wr && !prog_we;
    assign is_prom     = ioctl_addr >= PROM_START;
    assign prom_offset = ioctl_addr - PROM_START;
    assign take_prog   = accept && !is_prom;
    assign take_prom   = accept && is_prom;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            prog_we <= 1'b0;
            prom_we <= 1'b0;
        end else begin
            prom_we <= take_prom;               // Single cycle strobe
            if (take_prog) begin
                prog_we <= 1'b1;
            end else if (sdram_ack) begin
                prog_we <= 1'b0;                // Drops the cycle after ack
            end
        end
    end

    // Write fields hold while prog_we is high
    always_ff @(posedge clk) begin
        if (take_prog) begin
            prog.addr <= byte_to_word(ioctl_addr);
            prog.data <= ioctl_dout;
            // Even byte goes to the upper lane
            prog.mask <= {ioctl_addr[0], ~ioctl_addr[0]};
        end
        if (take_prom) begin
            prom.addr <= prom_addr_t'(prom_offset);
            prom.data <= ioctl_dout[3:0];       // PROMs are 4 bits wide
        end
    end

endmodule

// ==== source/kicker_frac_cen.sv ====
`timescale 1ns/1ps

module kicker_frac_cen #(
    parameter int W = 2,                // Number of enable outputs
    parameter int N = 16,
    parameter int M = 125
) (
    input  logic         clk,
    input  logic         arst_n,
    output logic [W-1:0] cen            // Bit i runs at N/M/2^i
);

    localparam int AW = $clog2(M + N) + 1;

    logic [AW-1:0] acc;
    logic [AW-1:0] acc_sum;
    logic [W-2:0]  div_cnt;             // Counts pulses of bit 0
    logic [W-1:0]  div_hit;

    assign acc_sum = acc + AW'(N);

    // Bit i fires when all lower divider bits are set
    always_comb begin
        div_hit    = '0;
        div_hit[0] = 1'b1;
        for (int i = 1; i < W; i++) begin
            div_hit[i] = div_hit[i-1] & div_cnt[i-1];
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            acc     <= '0;
            div_cnt <= '0;
            cen     <= '0;
        end else begin
            if (acc_sum >= AW'(M)) begin
                acc     <= acc_sum - AW'(M);    // Modulo M wrap
                div_cnt <= div_cnt + 1'b1;
                cen     <= div_hit;
            end else begin
                acc     <= acc_sum;
                cen     <= '0;
            end
        end
    end

endmodule

// ==== source/kicker_pkg.sv ====
package kicker_pkg;

    typedef logic [21:0] sdram_addr_t;  // SDRAM word address
    typedef logic [24:0] ioctl_addr_t;  // Loader byte address
    typedef logic [ 7:0] byte_t;
    typedef logic [15:0] word_t;
    typedef logic [17:0] gfx_addr_t;    // Graphics slot, word address
    typedef logic [16:0] main_addr_t;   // Main CPU slot, byte address
    typedef logic [ 8:0] prom_addr_t;

    // One SDRAM programming write
    typedef struct packed {
        sdram_addr_t addr;
        byte_t       data;
        logic [1:0]  mask;              // Active low, one bit per lane
    } prog_wr_t;

    typedef struct packed {
        prom_addr_t  addr;
        logic [3:0]  data;
    } prom_wr_t;

    typedef struct packed {
        logic        cs;
        gfx_addr_t   addr;              // Main slot reads the low 17 bits
    } slot_req_t;

    typedef struct packed {
        logic        req;
        sdram_addr_t addr;
    } rom_port_t;

    function automatic sdram_addr_t byte_to_word(ioctl_addr_t a);
        return sdram_addr_t'(a >> 1);
    endfunction

    function automatic sdram_addr_t gfx_to_sdram(sdram_addr_t offset, gfx_addr_t a);
        return offset + sdram_addr_t'(a);
    endfunction

    // Two main CPU bytes share one SDRAM word
    function automatic sdram_addr_t main_to_sdram(sdram_addr_t offset, main_addr_t a);
        return offset + sdram_addr_t'(a >> 1);
    endfunction

endpackage
